// File: vlog.f
verilog/fetch_pkg.sv
verilog/fetch_ctrl.sv
verilog/instr_obi_if.sv
verilog/fetch_resp_tracker.sv
verilog/fetch_top.sv
tb/obi_mem_model.sv
tb/fetch_asserts.sv
tb/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_subsystem

sources:
  - verilog/fetch_pkg.sv
  - verilog/fetch_ctrl.sv
  - verilog/instr_obi_if.sv
  - verilog/fetch_resp_tracker.sv
  - verilog/fetch_top.sv
  - target: test
    files:
      - tb/obi_mem_model.sv
      - tb/fetch_asserts.sv
      - tb/fetch_tb.sv

// File: tb/fetch_tb.sv
/*
  Table driven testbench for the fetch subsystem with one reset per test row.
  Transfer and response indices count from 0 after each reset, and fault rows use no branch.
*/
`timescale 1ns/1ps

module fetch_tb;
  import fetch_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int NUM_TESTS  = 6;

  typedef struct {
    string       name;
    logic        do_branch;
    int          branch_after;
    logic [31:0] branch_addr;
    int          n_consume;
    int          credit_delay;
    logic [1:0]  fault_kind;
    logic [3:0]  fault_idx;
  } test_row_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        branch_i;
  logic [31:0] branch_addr_i;
  logic        credit_return_i;
  logic        instr_valid_o;
  instr_t      instr_o;
  obi_a_chan_t obi_a;
  obi_gnt_t    obi_gnt;
  obi_r_chan_t obi_r;
  logic [1:0]  fault_kind;
  logic [3:0]  fault_idx;
  logic        achk_err;
  test_row_t   tests [NUM_TESTS];
  int          err_cnt  = 0;
  int          pass_cnt = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  fetch_top fetch_top_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .branch_i        (branch_i),
    .branch_addr_i   (branch_addr_i),
    .credit_return_i (credit_return_i),
    .instr_valid_o   (instr_valid_o),
    .instr_o         (instr_o),
    .obi_a_o         (obi_a),
    .obi_gnt_i       (obi_gnt),
    .obi_r_i         (obi_r)
  );

  obi_mem_model obi_mem_model_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .obi_a_i      (obi_a),
    .obi_gnt_o    (obi_gnt),
    .obi_r_o      (obi_r),
    .fault_kind_i (fault_kind),
    .fault_idx_i  (fault_idx),
    .achk_err_o   (achk_err)
  );

  ////////////////////////////////////////////////////////////////////
  // Checks on one delivered instruction
  ////////////////////////////////////////////////////////////////////

  task automatic check_instr(input string name, input logic [31:0] exp_pc, input logic exp_par);
    assert (instr_o.pc == exp_pc) else begin
      $display("ERR %s pc expected %h actual %h", name, exp_pc, instr_o.pc);
      err_cnt++;
    end
    // Memory returns the inverted address
    assert (instr_o.rdata == ~exp_pc) else begin
      $display("ERR %s rdata expected %h actual %h", name, ~exp_pc, instr_o.rdata);
      err_cnt++;
    end
    assert (instr_o.err == 1'b0) else begin
      $display("ERR %s err expected 0 actual %b", name, instr_o.err);
      err_cnt++;
    end
    assert (instr_o.parity_err == exp_par) else begin
      $display("ERR %s parity_err expected %b actual %b at pc %h",
               name, exp_par, instr_o.parity_err, exp_pc);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // One table row with reset, run and report
  ////////////////////////////////////////////////////////////////////

  task automatic run_test(input test_row_t row);
    int          cyc;
    int          recv;
    int          held;
    int          start_err;
    logic [31:0] exp_pc;
    logic        branched;
    logic        exp_par;
    int          due_q [$];
    start_err = err_cnt;
    cyc       = 0;
    recv      = 0;
    held      = 0;
    exp_pc    = RESET_PC;
    branched  = 1'b0;
    @(posedge clk);
    rst_n           <= 1'b0;
    branch_i        <= 1'b0;
    credit_return_i <= 1'b0;
    fault_kind      <= row.fault_kind;
    fault_idx       <= row.fault_idx;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    while (recv < row.n_consume) begin
      @(posedge clk);
      cyc++;
      // Single redirect once enough instructions came in
      if (row.do_branch && !branched && (recv == row.branch_after)) begin
        branch_i      <= 1'b1;
        branch_addr_i <= row.branch_addr;
        exp_pc        = row.branch_addr;
        branched      = 1'b1;
      end else begin
        branch_i <= 1'b0;
      end
      // Consumer gives back one credit per cycle at most
      if ((due_q.size() > 0) && (due_q[0] <= cyc)) begin
        credit_return_i <= 1'b1;
        void'(due_q.pop_front());
        held--;
      end else begin
        credit_return_i <= 1'b0;
      end
      @(negedge clk);
      if (instr_valid_o) begin
        exp_par = (row.fault_kind != 2'b00) && (recv == row.fault_idx);
        check_instr(row.name, exp_pc, exp_par);
        held++;
        assert (held <= FETCH_CREDITS) else begin
          $display("ERR %s unreturned instructions expected <= %0d actual %0d",
                   row.name, FETCH_CREDITS, held);
          err_cnt++;
        end
        due_q.push_back(cyc + row.credit_delay);
        recv++;
        exp_pc = exp_pc + 32'd4;
      end
    end
    assert (!achk_err) else begin
      $display("Memory model saw a wrong address checksum or attribute during %s", row.name);
      err_cnt++;
    end
    if (err_cnt == start_err) begin
      $display("PASS %s, %0d instructions in %0d cycles", row.name, recv, cyc);
      pass_cnt++;
    end else begin
      $display("FAIL %s, %0d errors", row.name, err_cnt - start_err);
    end
  endtask

  // name, branch, after, address, consume, credit delay, fault kind, fault index
  initial begin
    rst_n           = 1'b0;
    branch_i        = 1'b0;
    branch_addr_i   = '0;
    credit_return_i = 1'b0;
    fault_kind      = 2'b00;
    fault_idx       = 4'd0;
    tests[0] = '{"seq_fetch",      1'b0, 0, 32'h0000_0000, 8, 0,  2'b00, 4'd0};
    tests[1] = '{"redirect",       1'b1, 3, 32'h0000_1000, 8, 1,  2'b00, 4'd0};
    tests[2] = '{"backpressure",   1'b0, 0, 32'h0000_0000, 6, 30, 2'b00, 4'd0};
    tests[3] = '{"gnt_parity",     1'b0, 0, 32'h0000_0000, 5, 0,  2'b01, 4'd2};
    tests[4] = '{"rvalid_parity",  1'b0, 0, 32'h0000_0000, 5, 0,  2'b10, 4'd3};
    tests[5] = '{"redirect_stall", 1'b1, 2, 32'h0000_2040, 7, 6,  2'b00, 4'd0};
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(tests[i]);
    end
    assert (fetch_top_i.fetch_asserts_i.fail_cnt == 0) else begin
      $display("Bus protocol assertions failed %0d times", fetch_top_i.fetch_asserts_i.fail_cnt);
      err_cnt++;
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             NUM_TESTS, pass_cnt, NUM_TESTS - pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog allows 200 cycles per table row
  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("Watchdog timeout, a test did not receive all of its instructions");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: tb/fetch_asserts.sv
/*
  Bus protocol properties on the fetch top address channel.
  The failure count is read by the testbench at the end of the run.
*/
`timescale 1ns/1ps

module fetch_asserts (
  input logic                   clk,
  input logic                   rst_n,
  input fetch_pkg::obi_a_chan_t obi_a_o,
  input fetch_pkg::obi_gnt_t    obi_gnt_i,
  input fetch_pkg::obi_r_chan_t obi_r_i
);
  import fetch_pkg::*;

  logic [3:0] outstanding;
  int         fail_cnt = 0;

  // Granted but not yet answered
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + 4'(obi_a_o.req && obi_gnt_i.gnt) - 4'(obi_r_i.rvalid);
    end
  end

  // Ungranted request holds req and payload
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (obi_a_o.req && !obi_gnt_i.gnt) |=> (obi_a_o.req && $stable(obi_a_o.payload)))
    else begin
      $error("Address phase changed before its grant");
      fail_cnt++;
    end

  req_parity: assert property (@(posedge clk) disable iff (!rst_n)
    obi_a_o.reqpar == ~obi_a_o.req)
    else begin
      $error("reqpar is not the inverse of req");
      fail_cnt++;
    end

  max_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= MAX_OUTSTANDING)
    else begin
      $error("Too many outstanding bus transfers");
      fail_cnt++;
    end

endmodule

bind fetch_top fetch_asserts fetch_asserts_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .obi_a_o   (obi_a_o),
  .obi_gnt_i (obi_gnt_i),
  .obi_r_i   (obi_r_i)
);

// File: tb/obi_mem_model.sv
/*
  In-order OBI slave for instruction fetch, read only.
  Grants after 0 to 2 cycles and answers 1 to 2 cycles after the grant; rdata is the inverted address.
  Transfer and response counts restart at reset, and fault_idx_i selects one of them.
*/
`timescale 1ns/1ps

module obi_mem_model (
  input  logic                   clk,
  input  logic                   rst_n,
  input  fetch_pkg::obi_a_chan_t obi_a_i,
  output fetch_pkg::obi_gnt_t    obi_gnt_o,
  output fetch_pkg::obi_r_chan_t obi_r_o,
  // Bit 0 corrupts gntpar, bit 1 corrupts rvalidpar
  input  logic [1:0]             fault_kind_i,
  input  logic [3:0]             fault_idx_i,
  output logic                   achk_err_o
);
  import fetch_pkg::*;

  integer      seed = 32'h56770c8b;
  int          wait_q;
  int          delay_q;
  int          gnt_cnt;
  int          rsp_cnt;
  int          cyc;
  int          last_due;
  int          lat;
  int          due;
  logic [31:0] raddr;
  logic        gnt;
  // Granted addresses and due cycles of their responses in grant order
  logic [31:0] addr_fifo [$];
  int          due_fifo  [$];

  // Odd parity per group with the MSB group first
  function automatic logic [11:0] expected_achk(input obi_a_req_t p);
    logic [11:0] chk;
    chk[11:8] = 4'b1111;
    chk[7]    = 1'b1;
    chk[6]    = ~p.dbg;
    // Byte enables all set and we low give an even count of ones
    chk[5]    = 1'b1;
    chk[4]    = ~^{p.prot, p.memtype};
    chk[3]    = ~^p.addr[31:24];
    chk[2]    = ~^p.addr[23:16];
    chk[1]    = ~^p.addr[15:8];
    chk[0]    = ~^{p.addr[7:2], 2'b00};
    return chk;
  endfunction

  // Grant once the request has waited its drawn delay
  assign gnt              = obi_a_i.req && (wait_q >= delay_q);
  assign obi_gnt_o.gnt    = gnt;
  assign obi_gnt_o.gntpar = (fault_kind_i[0] && gnt && (gnt_cnt == fault_idx_i)) ? gnt : ~gnt;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_q     <= 0;
      delay_q    <= $unsigned($random(seed)) % 3;
      gnt_cnt    <= 0;
      rsp_cnt    <= 0;
      achk_err_o <= 1'b0;
      obi_r_o    <= '0;
      cyc        = 0;
      last_due   = 0;
      addr_fifo.delete();
      due_fifo.delete();
    end else begin
      cyc = cyc + 1;
      ////////////////////////////////////////////////////////////////////
      // Address phase
      ////////////////////////////////////////////////////////////////////
      if (obi_a_i.req) begin
        // Checksum and the fixed fetch attributes
        if ((obi_a_i.payload.achk != expected_achk(obi_a_i.payload)) ||
            (obi_a_i.payload.prot != FETCH_PROT) ||
            (obi_a_i.payload.memtype != FETCH_MEMTYPE) ||
            (obi_a_i.payload.dbg != FETCH_DBG)) begin
          achk_err_o <= 1'b1;
        end
        if (gnt) begin
          lat = 1 + ($unsigned($random(seed)) % 2);
          // Registered response shows up one cycle after its due cycle
          due = cyc + lat - 1;
          // Keep order with at most one response per cycle
          if (due <= last_due) begin
            due = last_due + 1;
          end
          last_due = due;
          addr_fifo.push_back(obi_a_i.payload.addr);
          due_fifo.push_back(due);
          gnt_cnt <= gnt_cnt + 1;
          wait_q  <= 0;
          delay_q <= $unsigned($random(seed)) % 3;
        end else begin
          wait_q <= wait_q + 1;
        end
      end
      ////////////////////////////////////////////////////////////////////
      // Response phase
      ////////////////////////////////////////////////////////////////////
      if ((due_fifo.size() > 0) && (due_fifo[0] == cyc)) begin
        raddr = addr_fifo.pop_front();
        void'(due_fifo.pop_front());
        obi_r_o.rvalid    <= 1'b1;
        // Corrupted pair is equal instead of inverted
        obi_r_o.rvalidpar <= fault_kind_i[1] && (rsp_cnt == fault_idx_i);
        obi_r_o.rdata     <= ~raddr;
        obi_r_o.err       <= 1'b0;
        obi_r_o.rchk      <= 5'd0;
        rsp_cnt           <= rsp_cnt + 1;
      end else begin
        obi_r_o           <= '0;
        obi_r_o.rvalidpar <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/fetch_top.sv
/*
  Instruction fetch subsystem top.
  Decode must pulse credit_return_i once per instruction it consumes.
*/
`timescale 1ns/1ps

module fetch_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   branch_i,
  input  logic [31:0]            branch_addr_i,
  input  logic                   credit_return_i,
  output logic                   instr_valid_o,
  output fetch_pkg::instr_t      instr_o,
  output fetch_pkg::obi_a_chan_t obi_a_o,
  input  fetch_pkg::obi_gnt_t    obi_gnt_i,
  input  fetch_pkg::obi_r_chan_t obi_r_i
);
  import fetch_pkg::*;

  // Controller to adapter
  logic        trans_valid;
  logic        trans_ready;
  fetch_req_t  trans;
  // Adapter to tracker
  logic        resp_valid;
  fetch_resp_t resp;
  // Tracker back to controller
  logic        drop;
  logic        flush;

  fetch_ctrl fetch_ctrl_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .branch_i        (branch_i),
    .branch_addr_i   (branch_addr_i),
    .credit_return_i (credit_return_i),
    .drop_i          (drop),
    .trans_ready_i   (trans_ready),
    .trans_valid_o   (trans_valid),
    .trans_o         (trans),
    .flush_o         (flush)
  );

  instr_obi_if instr_obi_if_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_ready_o (trans_ready),
    .trans_i       (trans),
    .resp_valid_o  (resp_valid),
    .resp_o        (resp),
    .obi_a_o       (obi_a_o),
    .obi_gnt_i     (obi_gnt_i),
    .obi_r_i       (obi_r_i)
  );

  // Tracker watches the address channel to capture granted fetch addresses
  fetch_resp_tracker fetch_resp_tracker_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush),
    .obi_a_i       (obi_a_o),
    .obi_gnt_i     (obi_gnt_i),
    .resp_valid_i  (resp_valid),
    .resp_i        (resp),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .drop_o        (drop)
  );

endmodule

// File: verilog/fetch_resp_tracker.sv
/*
  Pairs each fetch response with its address and drops stale ones after a redirect.
  Responses are in order and arrive at least one cycle after their grant.
*/
`timescale 1ns/1ps

module fetch_resp_tracker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  fetch_pkg::obi_a_chan_t obi_a_i,
  input  fetch_pkg::obi_gnt_t    obi_gnt_i,
  input  logic                   resp_valid_i,
  input  fetch_pkg::fetch_resp_t resp_i,
  output logic                   instr_valid_o,
  output fetch_pkg::instr_t      instr_o,
  output logic                   drop_o
);
  import fetch_pkg::*;

  logic [31:0]      addr_mem [MAX_OUTSTANDING];
  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] stale_q;
  logic [CNT_W-1:0] stale_d;
  logic             push;
  logic             stale;

  // Granted address enters, each response pops one
  assign push = obi_a_i.req && obi_gnt_i.gnt;

  ////////////////////////////////////////////////////////////////////
  // Stale response filter
  ////////////////////////////////////////////////////////////////////

  // A response in the flush cycle itself is also old
  assign stale         = flush_i || (stale_q != '0);
  assign instr_valid_o = resp_valid_i && !stale;
  assign drop_o        = resp_valid_i && stale;

  always_comb begin
    stale_d = stale_q;
    if (flush_i) begin
      // Everything in flight, a held request included, minus this cycle's response
      stale_d = cnt_q + CNT_W'(obi_a_i.req) - CNT_W'(resp_valid_i);
    end else if (drop_o) begin
      stale_d = stale_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      cnt_q   <= '0;
      stale_q <= '0;
    end else begin
      wptr_q  <= wptr_q + PTR_W'(push);
      rptr_q  <= rptr_q + PTR_W'(resp_valid_i);
      cnt_q   <= cnt_q + CNT_W'(push) - CNT_W'(resp_valid_i);
      stale_q <= stale_d;
    end
  end

  // Address storage
  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[wptr_q] <= obi_a_i.payload.addr;
    end
  end

  // Instruction assembly
  assign instr_o.pc         = addr_mem[rptr_q];
  assign instr_o.rdata      = resp_i.rdata;
  assign instr_o.err        = resp_i.err;
  assign instr_o.parity_err = resp_i.parity_err;

endmodule

// File: verilog/instr_obi_if.sv
/*
  OBI address phase adapter for instruction fetch.
  Does not limit outstanding transfers itself; the caller keeps them at MAX_OUTSTANDING.
  Responses are passed on in the rvalid cycle, the consumer is always ready. rchk is not checked.
*/
`timescale 1ns/1ps

module instr_obi_if (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   trans_valid_i,
  output logic                   trans_ready_o,
  input  fetch_pkg::fetch_req_t  trans_i,
  output logic                   resp_valid_o,
  output fetch_pkg::fetch_resp_t resp_o,
  output fetch_pkg::obi_a_chan_t obi_a_o,
  input  fetch_pkg::obi_gnt_t    obi_gnt_i,
  input  fetch_pkg::obi_r_chan_t obi_r_i
);
  import fetch_pkg::*;

  obi_if_state_e            state_q;
  obi_if_state_e            state_d;
  obi_a_req_t               trans_payload;
  obi_a_req_t               a_req_q;
  obi_a_req_t               a_payload;
  logic                     a_req;
  logic [11:0]              achk;
  // Bit 0 stays low so cnt_q indexes the oldest entry directly
  logic [MAX_OUTSTANDING:0] parity_fifo_q;
  logic [CNT_W-1:0]         cnt_q;
  logic                     a_accept;
  logic                     gntpar_err;
  logic                     gntpar_err_q;
  logic                     gntpar_err_resp;
  logic                     rvalidpar_err;

  ////////////////////////////////////////////////////////////////////
  // Address phase payload and checksum
  ////////////////////////////////////////////////////////////////////

  // Odd parity per group; write data, atop, be and we are fixed for fetch
  always_comb begin
    achk = {
      ~^8'h00,
      ~^8'h00,
      ~^8'h00,
      ~^8'h00,
      ~^6'h00,
      ~^FETCH_DBG,
      ~^{4'b1111, 1'b0},
      ~^{FETCH_PROT, FETCH_MEMTYPE},
      ~^trans_i.addr[31:24],
      ~^trans_i.addr[23:16],
      ~^trans_i.addr[15:8],
      ~^{trans_i.addr[7:2], 2'b00}
    };
  end

  always_comb begin
    trans_payload.addr    = {trans_i.addr[31:2], 2'b00};
    trans_payload.prot    = FETCH_PROT;
    trans_payload.memtype = FETCH_MEMTYPE;
    trans_payload.dbg     = FETCH_DBG;
    trans_payload.achk    = achk;
  end

  ////////////////////////////////////////////////////////////////////
  // Address phase FSM
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Ungranted request, hold it from registers from the next cycle
      OBI_TRANSPARENT: if (a_req && !obi_gnt_i.gnt) state_d = OBI_REGISTERED;
      // Grant ends the held request
      OBI_REGISTERED:  if (obi_gnt_i.gnt) state_d = OBI_TRANSPARENT;
      default:         state_d = OBI_TRANSPARENT;
    endcase
  end

  // Transparent passes trans straight through; registered never retracts
  assign a_req     = (state_q == OBI_TRANSPARENT) ? trans_valid_i : 1'b1;
  assign a_payload = (state_q == OBI_TRANSPARENT) ? trans_payload : a_req_q;

  assign obi_a_o.req     = a_req;
  assign obi_a_o.reqpar  = ~a_req;
  assign obi_a_o.payload = a_payload;

  assign trans_ready_o = (state_q == OBI_TRANSPARENT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= OBI_TRANSPARENT;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload snapshot, only taken on entry to the registered state
  always_ff @(posedge clk) begin
    if ((state_q == OBI_TRANSPARENT) && (state_d == OBI_REGISTERED)) begin
      a_req_q <= trans_payload;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Outstanding count and parity tracking
  ////////////////////////////////////////////////////////////////////

  assign a_accept = a_req && obi_gnt_i.gnt;

  // Inverted parity: an error when the pair is equal
  assign gntpar_err    = a_req && (obi_gnt_i.gnt == obi_gnt_i.gntpar);
  assign rvalidpar_err = obi_r_i.rvalid && (obi_r_i.rvalid == obi_r_i.rvalidpar);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q         <= '0;
      gntpar_err_q  <= 1'b0;
      parity_fifo_q <= '0;
    end else begin
      cnt_q <= cnt_q + CNT_W'(a_accept) - CNT_W'(obi_r_i.rvalid);
      // Sticky over a waited grant, cleared when the address phase ends
      if (a_req) begin
        gntpar_err_q <= obi_gnt_i.gnt ? 1'b0 : (gntpar_err || gntpar_err_q);
      end
      // Newest entry enters at bit 1
      if (a_accept) begin
        parity_fifo_q <= {parity_fifo_q[MAX_OUTSTANDING-1:1], gntpar_err || gntpar_err_q, 1'b0};
      end
    end
  end

  // Oldest outstanding grant result lines up with the current response
  assign gntpar_err_resp = parity_fifo_q[cnt_q];

  ////////////////////////////////////////////////////////////////////
  // Response channel
  ////////////////////////////////////////////////////////////////////

  assign resp_valid_o      = obi_r_i.rvalid;
  assign resp_o.rdata      = obi_r_i.rdata;
  assign resp_o.err        = obi_r_i.err;
  assign resp_o.parity_err = gntpar_err_resp || rvalidpar_err;

endmodule

// File: verilog/fetch_ctrl.sv
/*
  PC sequencing and decode credit control.
  A fetch is offered only while credits remain and no branch is present.
  Decode must return exactly one credit per consumed instruction.
*/
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  branch_i,
  input  logic [31:0]           branch_addr_i,
  input  logic                  credit_return_i,
  input  logic                  drop_i,
  input  logic                  trans_ready_i,
  output logic                  trans_valid_o,
  output fetch_pkg::fetch_req_t trans_o,
  output logic                  flush_o
);
  import fetch_pkg::*;

  logic [31:0]         pc_q;
  logic [CREDIT_W-1:0] credit_q;
  logic [CREDIT_W-1:0] credit_d;
  // Set one cycle after reset release, holds off the first offer until then
  logic                fetch_en_q;
  logic                spend;

  ////////////////////////////////////////////////////////////////////
  // Fetch offer
  ////////////////////////////////////////////////////////////////////

  // Branch cycle never offers, the new PC is fetched from the next cycle on
  assign trans_valid_o = fetch_en_q && (credit_q != '0) && !branch_i;
  assign trans_o.addr  = pc_q;

  // Transfer handshake with the bus adapter
  assign spend = trans_valid_o && trans_ready_i;

  // Tracker uses this to mark in-flight fetches as stale
  assign flush_o = branch_i;

  ////////////////////////////////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////////////////////////////////

  // Decode return and stale drop may both arrive with a spend in one cycle
  always_comb begin
    credit_d = credit_q;
    credit_d = credit_d + CREDIT_W'(credit_return_i);
    credit_d = credit_d + CREDIT_W'(drop_i);
    credit_d = credit_d - CREDIT_W'(spend);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_q   <= CREDIT_W'(FETCH_CREDITS);
      fetch_en_q <= 1'b0;
    end else begin
      credit_q   <= credit_d;
      fetch_en_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (branch_i) begin
      // Redirect wins, no transfer is accepted in this cycle
      pc_q <= branch_addr_i;
    end else if (spend) begin
      pc_q <= pc_q + 32'd4;
    end
  end

endmodule

// File: verilog/fetch_pkg.sv
/*
  Shared types and sizes for the fetch subsystem.
  MAX_OUTSTANDING must be a power of two (at least 2), and FETCH_CREDITS must not exceed it.
  Fetch attributes are fixed. No PMA/PMP, cache or compressed support.
*/
package fetch_pkg;

  // Sizing
  localparam int MAX_OUTSTANDING = 2;
  localparam int FETCH_CREDITS   = 2;
  // Counters also cover one request still waiting for its grant
  localparam int CNT_W           = $clog2(MAX_OUTSTANDING + 2);
  localparam int PTR_W           = $clog2(MAX_OUTSTANDING);
  localparam int CREDIT_W        = $clog2(FETCH_CREDITS + 1);

  // First fetch address
  localparam logic [31:0] RESET_PC = 32'h0000_0080;

  // Fixed attributes: machine mode instruction fetch, normal memory, no debug
  localparam logic [2:0] FETCH_PROT    = 3'b110;
  localparam logic [1:0] FETCH_MEMTYPE = 2'b00;
  localparam logic       FETCH_DBG     = 1'b0;

  // Address phase FSM
  typedef enum logic [0:0] {
    OBI_TRANSPARENT,
    OBI_REGISTERED
  } obi_if_state_e;

  ////////////////////////////////////////////////////////////////////
  // Bus channels
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  prot;
    logic [1:0]  memtype;
    logic        dbg;
    logic [11:0] achk;
  } obi_a_req_t;

  typedef struct packed {
    logic       req;
    logic       reqpar;
    obi_a_req_t payload;
  } obi_a_chan_t;

  typedef struct packed {
    logic gnt;
    logic gntpar;
  } obi_gnt_t;

  typedef struct packed {
    logic        rvalid;
    logic        rvalidpar;
    logic [31:0] rdata;
    logic        err;
    logic [4:0]  rchk;
  } obi_r_chan_t;

  ////////////////////////////////////////////////////////////////////
  // Fetch side
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [31:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
    logic        parity_err;
  } fetch_resp_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] rdata;
    logic        err;
    logic        parity_err;
  } instr_t;

endpackage
